// ==== hdl/tl2umi_pkg.sv ====
// Field layouts assume 64-bit UMI data and single-beat TileLink transfers of up to 8 bytes
package tl2umi_pkg;

    // TileLink A opcodes
    localparam logic [2:0] TL_OP_GET             = 3'd4;
    localparam logic [2:0] TL_OP_PUT_FULL        = 3'd0;
    localparam logic [2:0] TL_OP_PUT_PARTIAL     = 3'd1;

    // TileLink D opcodes
    localparam logic [2:0] TL_OP_ACCESS_ACK      = 3'd0;
    localparam logic [2:0] TL_OP_ACCESS_ACK_DATA = 3'd1;

    // UMI opcodes, requests and responses
    localparam logic [4:0] UMI_REQ_READ          = 5'd1;
    localparam logic [4:0] UMI_REQ_WRITE         = 5'd3;
    localparam logic [4:0] UMI_RESP_READ         = 5'd2;
    localparam logic [4:0] UMI_RESP_WRITE        = 5'd4;

    localparam int UMI_AW    = 64;
    localparam int UMI_DW    = 64;
    localparam int TL_AW     = 56;
    localparam int CHIPID_W  = 16;

    // TileLink field widths
    localparam int TL_SIZE_W = 3;
    localparam int TL_SRC_W  = 5;
    localparam int TL_MASK_W = UMI_DW / 8;

    typedef struct packed {
        logic [2:0]           opcode;
        logic [2:0]           param;
        logic [TL_SIZE_W-1:0] size;
        logic [TL_SRC_W-1:0]  source;
        logic [TL_AW-1:0]     address;
        logic [TL_MASK_W-1:0] mask;
        logic [UMI_DW-1:0]    data;
    } tl_a_t;

    // Param, sink, denied and corrupt are driven separately
    typedef struct packed {
        logic [2:0]           opcode;
        logic [TL_SIZE_W-1:0] size;
        logic [TL_SRC_W-1:0]  source;
        logic [UMI_DW-1:0]    data;
    } tl_d_t;

    typedef struct packed {
        logic [8:0] reserved;
        logic       eom;
        logic [5:0] qos_prot;
        logic [7:0] len;
        logic [2:0] size;
        logic [4:0] opcode;
    } umi_cmd_t;

    // Request srcaddr, echoed back as the response dstaddr
    typedef struct packed {
        logic [23:0] chipid;
        logic [7:0]  offset;
        logic [7:0]  size;
        logic [7:0]  source;
        logic [15:0] low;
    } umi_src_user_t;

    typedef struct packed {
        umi_cmd_t          cmd;
        logic [UMI_AW-1:0] dstaddr;
        logic [UMI_AW-1:0] srcaddr;
        logic [UMI_DW-1:0] data;
    } umi_pkt_t;

endpackage

// ==== hdl/sync_fifo.sv ====
// Writer must hold off while full is high; rd_data is only meaningful while rd_valid is high
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic nreset,
    input  logic wr_valid,
    input  T     wr_data,
    output logic full,
    output logic rd_valid,
    input  logic rd_ready,
    output T     rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic           push;
    logic           pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign pop  = rd_valid && rd_ready;
    // A pop in the same cycle frees a slot
    assign push = wr_valid && (!full || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/tl_req_xlate.sv ====
// Handles single-beat Get and Put of size 0 to 3 only; other opcodes and zero masks clear keep
`timescale 1ns/1ps

module tl_req_xlate
    import tl2umi_pkg::*;
(
    input  tl_a_t                beat,
    input  logic [CHIPID_W-1:0]  chipid,
    output umi_pkt_t             pkt,
    output logic                 keep
);

    logic [2:0]    offset;
    logic [3:0]    ones;
    logic [7:0]    mask_len;
    logic [7:0]    get_len;
    logic          mask_nz;
    umi_src_user_t src_user;

    // Lowest set mask bit and byte count
    always_comb begin
        offset = '0;
        ones   = '0;
        for (int i = TL_MASK_W - 1; i >= 0; i--) begin
            if (beat.mask[i]) begin
                offset = 3'(i);
                ones   = ones + 4'd1;
            end
        end
    end

    assign mask_nz  = |beat.mask;
    assign mask_len = 8'(ones) - 8'd1;
    assign get_len  = (8'd1 << beat.size) - 8'd1;

    // Context needed to rebuild the D beat from the response
    always_comb begin
        src_user        = '0;
        src_user.chipid = 24'(chipid);
        src_user.offset = 8'(offset);
        src_user.size   = 8'(beat.size);
        src_user.source = 8'(beat.source);
        src_user.low    = 16'h0000;
    end

    always_comb begin
        pkt              = '0;
        pkt.cmd.reserved = '0;
        pkt.cmd.eom      = 1'b1;
        pkt.cmd.qos_prot = '0;
        pkt.cmd.size     = 3'd0;
        pkt.dstaddr      = UMI_AW'({beat.address[TL_AW-1:3], offset});
        pkt.srcaddr      = src_user;
        keep             = 1'b0;

        case (beat.opcode)
            TL_OP_GET: begin
                pkt.cmd.opcode = UMI_REQ_READ;
                pkt.cmd.len    = get_len;
                pkt.data       = '0;
                keep           = mask_nz;
            end
            TL_OP_PUT_FULL,
            TL_OP_PUT_PARTIAL: begin
                pkt.cmd.opcode = UMI_REQ_WRITE;
                pkt.cmd.len    = mask_len;
                // Packed bytes start at bit 0
                pkt.data       = beat.data >> {offset, 3'b000};
                keep           = mask_nz;
            end
            default: begin
                pkt.cmd.opcode = '0;
                pkt.cmd.len    = '0;
                pkt.data       = '0;
                keep           = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/umi_resp_xlate.sv ====
// Expects dstaddr in the request srcaddr layout; responses other than read and write clear keep
`timescale 1ns/1ps

module umi_resp_xlate
    import tl2umi_pkg::*;
(
    input  umi_pkt_t pkt,
    output tl_d_t    beat,
    output logic     keep
);

    umi_src_user_t dst_user;

    assign dst_user = pkt.dstaddr;

    always_comb begin
        beat.opcode = TL_OP_ACCESS_ACK;
        beat.size   = dst_user.size[TL_SIZE_W-1:0];
        beat.source = dst_user.source[TL_SRC_W-1:0];
        beat.data   = '0;
        keep        = 1'b0;

        case (pkt.cmd.opcode)
            UMI_RESP_READ: begin
                beat.opcode = TL_OP_ACCESS_ACK_DATA;
                // Back to the lane of the original request
                beat.data   = pkt.data << {dst_user.offset[2:0], 3'b000};
                keep        = 1'b1;
            end
            UMI_RESP_WRITE: begin
                beat.opcode = TL_OP_ACCESS_ACK;
                keep        = 1'b1;
            end
            default: begin
                keep = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/tl2umi_top.sv ====
// chipid must stay static; dropped A beats and responses still wait for their queue to have room
`timescale 1ns/1ps

module tl2umi_top
    import tl2umi_pkg::*;
#(
    parameter int REQ_DEPTH  = 2,
    parameter int RESP_DEPTH = 2
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic [CHIPID_W-1:0] chipid,

    // TileLink A
    input  logic                a_valid,
    output logic                a_ready,
    input  tl_a_t               a_beat,

    // TileLink D
    output logic                d_valid,
    input  logic                d_ready,
    output tl_d_t               d_beat,
    output logic [1:0]          d_param,
    output logic                d_sink,
    output logic                d_denied,
    output logic                d_corrupt,

    // UMI host request
    output logic                req_valid,
    input  logic                req_ready,
    output umi_pkt_t            req_pkt,

    // UMI host response
    input  logic                resp_valid,
    output logic                resp_ready,
    input  umi_pkt_t            resp_pkt
);

    umi_pkt_t xlate_pkt;
    logic     req_keep;
    logic     req_full;
    tl_d_t    xlate_beat;
    logic     resp_keep;
    logic     resp_full;

    assign a_ready    = !req_full;
    assign resp_ready = !resp_full;

    assign d_param   = 2'b00;
    assign d_sink    = 1'b0;
    assign d_denied  = 1'b0;
    assign d_corrupt = 1'b0;

    tl_req_xlate u_req_xlate (
        .beat   (a_beat),
        .chipid (chipid),
        .pkt    (xlate_pkt),
        .keep   (req_keep)
    );

    sync_fifo #(
        .T     (umi_pkt_t),
        .DEPTH (REQ_DEPTH)
    ) u_req_q (
        .clk      (clk),
        .nreset   (nreset),
        .wr_valid (a_valid && a_ready && req_keep),
        .wr_data  (xlate_pkt),
        .full     (req_full),
        .rd_valid (req_valid),
        .rd_ready (req_ready),
        .rd_data  (req_pkt)
    );

    umi_resp_xlate u_resp_xlate (
        .pkt  (resp_pkt),
        .beat (xlate_beat),
        .keep (resp_keep)
    );

    sync_fifo #(
        .T     (tl_d_t),
        .DEPTH (RESP_DEPTH)
    ) u_resp_q (
        .clk      (clk),
        .nreset   (nreset),
        .wr_valid (resp_valid && resp_ready && resp_keep),
        .wr_data  (xlate_beat),
        .full     (resp_full),
        .rd_valid (d_valid),
        .rd_ready (d_ready),
        .rd_data  (d_beat)
    );

endmodule

// ==== bench/tl2umi_props.sv ====
// Bound into tl2umi_top; checks hold-until-taken on both outputs and idle outputs after reset
`timescale 1ns/1ps

module tl2umi_props
    import tl2umi_pkg::*;
(
    input logic     clk,
    input logic     nreset,
    input logic     req_valid,
    input logic     req_ready,
    input umi_pkt_t req_pkt,
    input logic     d_valid,
    input logic     d_ready,
    input tl_d_t    d_beat
);

    int unsigned assert_fails = 0;

    // Request held until taken
    a_req_hold: assert property (@(posedge clk) disable iff (!nreset)
        req_valid && !req_ready |=> req_valid && $stable(req_pkt))
    else begin
        assert_fails++;
        $error("req_valid dropped or req_pkt changed while req_ready was low");
    end

    a_d_hold: assert property (@(posedge clk) disable iff (!nreset)
        d_valid && !d_ready |=> d_valid && $stable(d_beat))
    else begin
        assert_fails++;
        $error("d_valid dropped or d_beat changed while d_ready was low");
    end

    a_idle_after_reset: assert property (@(posedge clk) $rose(nreset) |-> !req_valid && !d_valid)
    else begin
        assert_fails++;
        $error("valid output high in the first cycle after reset");
    end

endmodule

bind tl2umi_top tl2umi_props u_props (
    .clk       (clk),
    .nreset    (nreset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_pkt   (req_pkt),
    .d_valid   (d_valid),
    .d_ready   (d_ready),
    .d_beat    (d_beat)
);

// ==== bench/tb_tl2umi.sv ====
// Directed tests at default queue depths of 2; relies on the bound props module's failure count
`timescale 1ns/1ps

module tb_tl2umi
    import tl2umi_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CNT    = 6;
    localparam int TEST_CYCLES = 200;

    logic                clk;
    logic                nreset;
    logic [CHIPID_W-1:0] chipid;
    logic                a_valid;
    logic                a_ready;
    tl_a_t               a_beat;
    logic                d_valid;
    logic                d_ready;
    tl_d_t               d_beat;
    logic [1:0]          d_param;
    logic                d_sink;
    logic                d_denied;
    logic                d_corrupt;
    logic                req_valid;
    logic                req_ready;
    umi_pkt_t            req_pkt;
    logic                resp_valid;
    logic                resp_ready;
    umi_pkt_t            resp_pkt;
    integer              seed;

    tl2umi_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CNT * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in %0d ns",
                 TEST_CNT * TEST_CYCLES * CLK_PERIOD);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_umi_req(input umi_pkt_t got, input umi_pkt_t exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED req_pkt: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_tl_d(input tl_d_t got, input tl_d_t exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED d_beat: got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_param(input string name, input logic [1:0] got,
                                 input logic [1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Srcaddr layout: chipid, offset, size, source, zero low half-word
    function automatic logic [63:0] user_addr(input logic [2:0] offset, input logic [2:0] size,
                                              input logic [4:0] source);
        return {8'h00, chipid, 5'd0, offset, 5'd0, size, 3'd0, source, 16'h0000};
    endfunction

    function automatic umi_pkt_t build_req_pkt(input logic [4:0] opcode, input logic [7:0] len,
                                               input logic [TL_AW-1:0] addr,
                                               input logic [2:0] offset, input logic [2:0] size,
                                               input logic [4:0] source, input logic [63:0] data);
        umi_pkt_t p;
        p.cmd     = umi_cmd_t'{9'd0, 1'b1, 6'd0, len, 3'd0, opcode};
        p.dstaddr = {8'h00, addr[TL_AW-1:3], offset};
        p.srcaddr = user_addr(offset, size, source);
        p.data    = data;
        return p;
    endfunction

    function automatic umi_pkt_t build_resp_pkt(input logic [4:0] opcode, input logic [2:0] offset,
                                                input logic [2:0] size, input logic [4:0] source,
                                                input logic [63:0] data);
        umi_pkt_t p;
        p.cmd     = umi_cmd_t'{9'd0, 1'b1, 6'd0, 8'd0, 3'd0, opcode};
        p.dstaddr = user_addr(offset, size, source);
        p.srcaddr = '0;
        p.data    = data;
        return p;
    endfunction

    task automatic send_a(input tl_a_t beat);
        @(posedge clk);
        a_valid <= 1'b1;
        a_beat  <= beat;
        @(negedge clk);
        while (!a_ready) @(negedge clk);
        @(posedge clk);
        a_valid <= 1'b0;
    endtask

    task automatic send_resp(input umi_pkt_t pkt);
        @(posedge clk);
        resp_valid <= 1'b1;
        resp_pkt   <= pkt;
        @(negedge clk);
        while (!resp_ready) @(negedge clk);
        @(posedge clk);
        resp_valid <= 1'b0;
    endtask

    task automatic recv_req(input umi_pkt_t exp);
        @(posedge clk);
        req_ready <= 1'b1;
        @(negedge clk);
        while (!req_valid) @(negedge clk);
        check_umi_req(req_pkt, exp);
        @(posedge clk);
        req_ready <= 1'b0;
    endtask

    task automatic recv_d(input tl_d_t exp);
        @(posedge clk);
        d_ready <= 1'b1;
        @(negedge clk);
        while (!d_valid) @(negedge clk);
        check_tl_d(d_beat, exp);
        // D fields outside tl_d_t are always zero
        compare_param("d_param", d_param, 2'b00);
        compare_bit("d_sink", d_sink, 1'b0);
        compare_bit("d_denied", d_denied, 1'b0);
        compare_bit("d_corrupt", d_corrupt, 1'b0);
        @(posedge clk);
        d_ready <= 1'b0;
    endtask

    task automatic expect_no_output(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_bit("req_valid", req_valid, 1'b0);
            compare_bit("d_valid", d_valid, 1'b0);
        end
    endtask

    task automatic test_get();
        logic [TL_AW-1:0] addr;
        addr = TL_AW'({$random(seed), $random(seed)});
        send_a(tl_a_t'{TL_OP_GET, 3'd0, 3'd2, 5'd7, addr, 8'hF0, 64'd0});
        recv_req(build_req_pkt(UMI_REQ_READ, 8'd3, addr, 3'd4, 3'd2, 5'd7, 64'd0));
    endtask

    task automatic test_put_full();
        logic [TL_AW-1:0] addr;
        logic [63:0]      data;
        addr = TL_AW'({$random(seed), $random(seed)});
        data = {$random(seed), $random(seed)};
        send_a(tl_a_t'{TL_OP_PUT_FULL, 3'd0, 3'd3, 5'd3, addr, 8'hFF, data});
        recv_req(build_req_pkt(UMI_REQ_WRITE, 8'd7, addr, 3'd0, 3'd3, 5'd3, data));
    endtask

    task automatic test_put_partial();
        logic [TL_AW-1:0] addr;
        logic [63:0]      data;
        addr = TL_AW'({$random(seed), $random(seed)});
        data = {$random(seed), $random(seed)};
        send_a(tl_a_t'{TL_OP_PUT_PARTIAL, 3'd0, 3'd2, 5'd12, addr, 8'h3C, data});
        // Bytes 2 to 5 land at the bottom
        recv_req(build_req_pkt(UMI_REQ_WRITE, 8'd3, addr, 3'd2, 3'd2, 5'd12,
                               {16'h0000, data[63:16]}));
    endtask

    task automatic test_read_resp();
        logic [63:0] data;
        data = {$random(seed), $random(seed)};
        send_resp(build_resp_pkt(UMI_RESP_READ, 3'd4, 3'd2, 5'd9, data));
        recv_d(tl_d_t'{TL_OP_ACCESS_ACK_DATA, 3'd2, 5'd9, {data[31:0], 32'h0000_0000}});
    endtask

    task automatic test_dropped();
        logic [TL_AW-1:0] addr;
        logic [63:0]      data;
        addr = TL_AW'({$random(seed), $random(seed)});
        data = {$random(seed), $random(seed)};
        send_a(tl_a_t'{3'd2, 3'd0, 3'd3, 5'd4, addr, 8'hFF, data});
        send_a(tl_a_t'{TL_OP_PUT_PARTIAL, 3'd0, 3'd2, 5'd5, addr, 8'h00, data});
        expect_no_output(4);
        send_resp(build_resp_pkt(5'd6, 3'd0, 3'd3, 5'd20, data));
        expect_no_output(4);
        send_resp(build_resp_pkt(UMI_RESP_WRITE, 3'd0, 3'd3, 5'd21, data));
        recv_d(tl_d_t'{TL_OP_ACCESS_ACK, 3'd3, 5'd21, 64'd0});
    endtask

    task automatic test_backpressure();
        tl_a_t            beats [3];
        umi_pkt_t         reqs [3];
        umi_pkt_t         resps [3];
        tl_d_t            d_exps [3];
        logic [TL_AW-1:0] addr;
        logic [63:0]      data;
        for (int i = 0; i < 3; i++) begin
            addr      = TL_AW'({$random(seed), $random(seed)});
            data      = {$random(seed), $random(seed)};
            beats[i]  = tl_a_t'{TL_OP_PUT_FULL, 3'd0, 3'd3, 5'(i + 1), addr, 8'hFF, data};
            reqs[i]   = build_req_pkt(UMI_REQ_WRITE, 8'd7, addr, 3'd0, 3'd3, 5'(i + 1), data);
            resps[i]  = build_resp_pkt(UMI_RESP_READ, 3'd0, 3'd3, 5'(i + 17), data);
            d_exps[i] = tl_d_t'{TL_OP_ACCESS_ACK_DATA, 3'd3, 5'(i + 17), data};
        end
        send_a(beats[0]);
        send_a(beats[1]);
        fork
            send_a(beats[2]);
            begin
                repeat (3) @(negedge clk);
                compare_bit("a_ready", a_ready, 1'b0);
                for (int i = 0; i < 3; i++) recv_req(reqs[i]);
            end
        join
        send_resp(resps[0]);
        send_resp(resps[1]);
        fork
            send_resp(resps[2]);
            begin
                repeat (3) @(negedge clk);
                compare_bit("resp_ready", resp_ready, 1'b0);
                for (int i = 0; i < 3; i++) recv_d(d_exps[i]);
            end
        join
    endtask

    initial begin
        seed       = 69498;
        nreset     = 1'b0;
        chipid     = 16'hC3A5;
        a_valid    = 1'b0;
        a_beat     = '0;
        d_ready    = 1'b0;
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_pkt   = '0;
        repeat (10) @(posedge clk);
        nreset <= 1'b1;
        @(negedge clk);
        compare_bit("a_ready", a_ready, 1'b1);
        compare_bit("resp_ready", resp_ready, 1'b1);
        expect_no_output(1);
        test_get();
        test_put_full();
        test_put_partial();
        test_read_resp();
        test_dropped();
        test_backpressure();
        repeat (4) @(posedge clk);
        if (u_dut.u_props.assert_fails == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("%0d handshake assertions fired", u_dut.u_props.assert_fails);
            $display("Verification failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== verilog.f ====
hdl/tl2umi_pkg.sv
hdl/sync_fifo.sv
hdl/tl_req_xlate.sv
hdl/umi_resp_xlate.sv
hdl/tl2umi_top.sv
bench/tl2umi_props.sv
bench/tb_tl2umi.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the TileLink to UMI testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_tl2umi -f verilog.f -o sim_tl2umi

# The simulator exits non-zero on failure; the log decides the result
./obj_dir/sim_tl2umi > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
